/* logic/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [15:0] addr_t;                    // Bus address
    typedef logic [7:0]  byte_t;                    // Data byte

    // Cycle states; each addressing mode walks its own path
    typedef enum logic [3:0] {
        RESET0,                                     // Present vector low address
        RESET1,                                     // Present vector high address
        RESET2,                                     // Jump through the vector
        DECODE,                                     // Opcode on din, write back previous result
        FETCH,                                      // Operand on din, fetch next opcode
        REG,                                        // Register-only instruction
        ZP0,                                        // Zero page access
        ABS0,                                       // Absolute low byte
        ABS1,                                       // Absolute access
        BRA0,                                       // Offset plus pc low
        BRA1,                                       // Taken, adjust page
        BRA2,                                       // Page crossed
        JMP0,                                       // Target low byte
        JMP1                                        // Target high byte
    } state_t;

    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,
        OP_SUB,                                     // Add with inverted B
        OP_PASS                                     // B operand straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    // Decoded instruction, latched at DECODE
    typedef struct packed {
        alu_op_t  op;                               // Main ALU operation
        reg_sel_t src_reg;                          // Operand or store source
        reg_sel_t dst_reg;                          // Written at next DECODE
        logic     load_reg;                         // Result goes to dst_reg
        logic     load_only;                        // LDA/LDX/LDY
        logic     store;                            // STA/STX/STY
        logic     compare;                          // CMP/CPX/CPY
        logic     adc_sbc;                          // ADC/SBC
        logic     inc;                              // INX/INY carry in
        logic     clc;
        logic     sec;
        logic     clv;
    } ctrl_t;

    typedef struct packed {
        byte_t ai;
        byte_t bi;
        logic  ci;
    } alu_in_t;

    typedef struct packed {
        byte_t result;
        logic  co;
        logic  z;
        logic  n;
        logic  v;
    } alu_out_t;

    localparam byte_t ZERO_PAGE = 8'h00;            // High byte of zero page addresses

endpackage

/* logic/bus_in.sv */
`timescale 1ns/1ps

module bus_in (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::byte_t di,
    input  logic           rdy,
    output cpu_pkg::byte_t din
);
    import cpu_pkg::*;

    logic  rdy_d;                                   // rdy one cycle late
    byte_t di_hold;                                 // Read data caught as the stall starts

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdy_d <= 1'b1;
        end else begin
            rdy_d <= rdy;
        end
    end

    // Memory moves on during a stall, keep the byte the core still needs
    always_ff @(posedge clk) begin
        if (!rdy && rdy_d) begin
            di_hold <= di;
        end
    end

    assign din = rdy_d ? di : di_hold;              // Held byte until the first cycle after stall

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic            clk,
    input  logic            reset,
    input  logic            rdy,
    input  cpu_pkg::state_t state,
    input  cpu_pkg::byte_t  din,
    output cpu_pkg::ctrl_t  ctrl
);
    import cpu_pkg::*;

    ctrl_t dec;                                     // Decode of the opcode now on din

    // Transfers, increments and decrements all share this shape
    function automatic ctrl_t reg_op(reg_sel_t src, reg_sel_t dst, alu_op_t op, logic inc);
        ctrl_t c;
        c          = '0;
        c.op       = op;
        c.src_reg  = src;
        c.dst_reg  = dst;
        c.load_reg = 1'b1;
        c.inc      = inc;
        return c;
    endfunction

    // Low opcode bits pick the register for loads and stores
    function automatic reg_sel_t column_reg(logic [1:0] cc);
        case (cc)
            2'b00:   return SEL_Y;
            2'b10:   return SEL_X;
            default: return SEL_A;
        endcase
    endfunction

    always_comb begin
        dec = '0;                                   // Unknown opcodes write nothing
        casez (din)
            8'hAA: dec = reg_op(SEL_A, SEL_X, OP_ADD, 1'b0);     // TAX
            8'hA8: dec = reg_op(SEL_A, SEL_Y, OP_ADD, 1'b0);     // TAY
            8'h8A: dec = reg_op(SEL_X, SEL_A, OP_ADD, 1'b0);     // TXA
            8'h98: dec = reg_op(SEL_Y, SEL_A, OP_ADD, 1'b0);     // TYA
            8'hE8: dec = reg_op(SEL_X, SEL_X, OP_ADD, 1'b1);     // INX
            8'hC8: dec = reg_op(SEL_Y, SEL_Y, OP_ADD, 1'b1);     // INY
            8'hCA: dec = reg_op(SEL_X, SEL_X, OP_SUB, 1'b0);     // DEX
            8'h88: dec = reg_op(SEL_Y, SEL_Y, OP_SUB, 1'b0);     // DEY
            8'h18: dec.clc = 1'b1;
            8'h38: dec.sec = 1'b1;
            8'hB8: dec.clv = 1'b1;
            8'b1000_?1?0, 8'b1000_?101: begin       // STY, STA, STX
                dec.store   = 1'b1;
                dec.src_reg = column_reg(din[1:0]);
            end
            8'b1010_00?0, 8'b1010_1001,
            8'b1010_?1?0, 8'b1010_?101: begin       // LDY, LDA, LDX
                dec.op        = OP_ADD;             // Zero plus operand
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
                dec.dst_reg   = column_reg(din[1:0]);
            end
            8'b11?0_0?00, 8'b11?0_1100: begin       // CPY, CPX
                dec.op      = OP_SUB;
                dec.compare = 1'b1;
                dec.src_reg = din[5] ? SEL_X : SEL_Y;
            end
            8'b11?0_1001, 8'b11?0_?101: begin       // CMP, SBC
                dec.op       = OP_SUB;
                dec.compare  = !din[5];
                dec.adc_sbc  = din[5];
                dec.load_reg = din[5];
            end
            8'b0??0_1001, 8'b0??0_?101: begin       // ORA, AND, EOR, ADC
                dec.op       = alu_op_t'({1'b0, din[6:5]});
                dec.adc_sbc  = (din[6:5] == 2'b11);
                dec.load_reg = 1'b1;
            end
            default: ;                              // Branches and JMP need no control
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= '0;
        end else if (rdy && state == DECODE) begin
            ctrl <= dec;
        end
    end

endmodule

/* logic/sequencer.sv */
`timescale 1ns/1ps

module sequencer #(
    parameter cpu_pkg::addr_t RESET_VECTOR = 16'hfffc
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::byte_t    din,
    input  cpu_pkg::ctrl_t    ctrl,
    input  cpu_pkg::flags_t   flags,
    input  cpu_pkg::alu_out_t alu_out,
    input  cpu_pkg::byte_t    regfile_out,
    output cpu_pkg::state_t   state,
    output cpu_pkg::addr_t    pc,
    output cpu_pkg::alu_in_t  alu_in,
    output cpu_pkg::alu_op_t  alu_op
);
    import cpu_pkg::*;

    state_t     state_next;
    addr_t      pc_base;                            // pc before the optional increment
    logic       pc_inc;
    logic [2:0] cond_code;                          // Branch opcode bits 7:5
    logic       cond_flag;
    logic       taken;
    logic       backwards;                          // Negative branch offset
    logic       crossed;                            // Branch target in another page
    byte_t      bra_page;                           // Page of the instruction after the branch

    assign crossed = alu_out.co ^ backwards;

    always_comb begin
        case (cond_code[2:1])
            2'b00:   cond_flag = flags.n;
            2'b01:   cond_flag = flags.v;
            2'b10:   cond_flag = flags.c;
            default: cond_flag = flags.z;
        endcase
        taken = (cond_flag == cond_code[0]);        // Bit 0 set means branch on flag set
    end

    always_comb begin
        state_next = state;
        case (state)
            RESET0: state_next = RESET1;
            RESET1: state_next = RESET2;
            RESET2: state_next = DECODE;
            DECODE: begin
                casez (din)
                    8'h4C:        state_next = JMP0;
                    8'b???1_0000: state_next = BRA0;
                    8'b???0_01??: state_next = ZP0;
                    8'b???0_11??: state_next = ABS0;
                    8'b???0_1001: state_next = FETCH;   // Immediate, group one
                    8'b1??0_00?0: state_next = FETCH;   // LDY, LDX, CPY, CPX immediate
                    default:      state_next = REG;     // Register, flag and unknown
                endcase
            end
            ZP0:    state_next = FETCH;
            ABS0:   state_next = ABS1;
            ABS1:   state_next = FETCH;
            BRA0:   state_next = taken ? BRA1 : DECODE;
            BRA1:   state_next = crossed ? BRA2 : DECODE;
            JMP0:   state_next = JMP1;
            FETCH, REG, BRA2, JMP1: state_next = DECODE;
            default: state_next = RESET0;
        endcase
    end

    always_comb begin
        pc_base = pc;
        pc_inc  = 1'b0;
        case (state)
            RESET2, JMP1: begin
                pc_base = {din, alu_out.result};    // High byte on din, low byte in ALU
                pc_inc  = 1'b1;
            end
            DECODE, FETCH, ABS0, BRA0: pc_inc = 1'b1;
            BRA1: begin
                pc_base = {bra_page, alu_out.result};
                pc_inc  = !crossed;                 // Opcode fetched now unless page moves
            end
            BRA2: begin
                pc_base = {alu_out.result, pc[7:0]};
                pc_inc  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= RESET0;
            pc        <= RESET_VECTOR;              // Parked until RESET2 loads the vector
            cond_code <= 3'b000;
            backwards <= 1'b0;
        end else if (rdy) begin
            state <= state_next;
            pc    <= pc_base + addr_t'(pc_inc);
            if (state == DECODE) begin
                cond_code <= din[7:5];
            end
            if (state == BRA0) begin
                backwards <= din[7];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state == BRA0) begin
            bra_page <= pc[15:8];
        end
    end

    always_comb begin
        alu_in.ai = 8'h00;                          // Default passes din through
        alu_in.bi = din;
        alu_in.ci = 1'b0;
        alu_op    = OP_PASS;
        case (state)
            FETCH: begin
                alu_in.ai = ctrl.load_only ? 8'h00 : regfile_out;
                alu_in.ci = ctrl.compare | (!ctrl.load_only & flags.c);
                alu_op    = ctrl.op;
            end
            REG: begin
                alu_in.ai = regfile_out;
                alu_in.bi = 8'h00;
                alu_in.ci = ctrl.inc;               // Plus one for INX/INY
                alu_op    = ctrl.op;
            end
            BRA0: begin
                alu_in.ai = din;                    // Offset plus pc low
                alu_in.bi = pc[7:0];
                alu_op    = OP_ADD;
            end
            BRA1: begin
                alu_in.ai = bra_page;               // Page fix, used only if crossed
                alu_in.bi = 8'h00;
                alu_in.ci = alu_out.co;
                alu_op    = backwards ? OP_SUB : OP_ADD;
            end
            default: ;
        endcase
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              rdy,
    input  cpu_pkg::alu_in_t  alu_in,
    input  cpu_pkg::alu_op_t  op,
    output cpu_pkg::alu_out_t alu_out
);
    import cpu_pkg::*;

    byte_t      bi;                                 // B operand, inverted for subtract
    logic [8:0] sum;                                // Result with carry out
    logic       v;

    always_comb begin
        bi = (op == OP_SUB) ? ~alu_in.bi : alu_in.bi;
        case (op)
            OP_OR:          sum = {1'b0, alu_in.ai | alu_in.bi};
            OP_AND:         sum = {1'b0, alu_in.ai & alu_in.bi};
            OP_EOR:         sum = {1'b0, alu_in.ai ^ alu_in.bi};
            OP_ADD, OP_SUB: sum = {1'b0, alu_in.ai} + {1'b0, bi} + 9'(alu_in.ci);
            default:        sum = {1'b0, alu_in.bi};
        endcase
        v = (alu_in.ai[7] == bi[7]) && (sum[7] != alu_in.ai[7]);    // Signed overflow
    end

    // Flags come from the same registered operation as the result
    always_ff @(posedge clk) begin
        if (rdy) begin
            alu_out.result <= sum[7:0];
            alu_out.co     <= sum[8];               // Carry, or no borrow on subtract
            alu_out.z      <= (sum[7:0] == 8'h00);
            alu_out.n      <= sum[7];
            alu_out.v      <= v;
        end
    end

endmodule

/* logic/reg_flags.sv */
`timescale 1ns/1ps

module reg_flags (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::state_t   state,
    input  cpu_pkg::ctrl_t    ctrl,
    input  cpu_pkg::alu_out_t alu_out,
    output cpu_pkg::byte_t    regfile_out,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    byte_t    regs [0:2];                           // A, X, Y
    reg_sel_t sel;
    logic     wr_reg;
    logic     upd;                                  // Flag update slot

    assign sel         = (state == DECODE) ? ctrl.dst_reg : ctrl.src_reg;
    assign regfile_out = regs[sel];
    assign upd         = rdy && (state == DECODE);
    assign wr_reg      = upd && ctrl.load_reg;

    // Previous result lands while the next opcode decodes
    always_ff @(posedge clk) begin
        if (wr_reg) begin
            regs[sel] <= alu_out.result;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (upd) begin
            if (ctrl.adc_sbc || ctrl.compare) begin
                flags.c <= alu_out.co;
            end else if (ctrl.sec) begin
                flags.c <= 1'b1;
            end else if (ctrl.clc) begin
                flags.c <= 1'b0;
            end
            if (ctrl.adc_sbc) begin
                flags.v <= alu_out.v;
            end else if (ctrl.clv) begin
                flags.v <= 1'b0;
            end
            if (ctrl.load_reg || ctrl.compare) begin    // Any register load or compare
                flags.n <= alu_out.n;
                flags.z <= alu_out.z;
            end
        end
    end

endmodule

/* logic/bus_out.sv */
`timescale 1ns/1ps

module bus_out #(
    parameter cpu_pkg::addr_t RESET_VECTOR = 16'hfffc
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              rdy,
    input  cpu_pkg::state_t   state,
    input  cpu_pkg::ctrl_t    ctrl,
    input  cpu_pkg::addr_t    pc,
    input  cpu_pkg::byte_t    din,
    input  cpu_pkg::alu_out_t alu_out,
    input  cpu_pkg::byte_t    regfile_out,
    output cpu_pkg::addr_t    ab,
    output cpu_pkg::byte_t    do_data,
    output logic              we
);
    import cpu_pkg::*;

    addr_t hold;                                    // Address of the previous cycle

    always_comb begin
        case (state)
            RESET0:             ab = RESET_VECTOR;
            RESET1:             ab = {RESET_VECTOR[15:1], 1'b1};
            RESET2, ABS1, JMP1: ab = {din, alu_out.result};
            ZP0:                ab = {ZERO_PAGE, din};
            REG:                ab = hold;          // pc already one ahead
            BRA1:               ab = {hold[15:8], alu_out.result};
            BRA2:               ab = {alu_out.result, hold[7:0]};
            default:            ab = pc;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hold <= RESET_VECTOR;
        end else if (rdy) begin
            hold <= ab;
        end
    end

    assign do_data = regfile_out;                   // src_reg selected outside DECODE
    assign we      = ctrl.store && (state == ZP0 || state == ABS1);

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::addr_t RESET_VECTOR = 16'hfffc
) (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::byte_t di,
    input  logic           rdy,
    output cpu_pkg::addr_t ab,
    output cpu_pkg::byte_t do_data,
    output logic           we
);
    import cpu_pkg::*;

    byte_t    din;                                  // Read data, held across stalls
    ctrl_t    ctrl;
    state_t   state;
    addr_t    pc;
    alu_in_t  alu_in;
    alu_op_t  alu_op;                               // Per-state ALU operation
    alu_out_t alu_out;
    byte_t    regfile_out;
    flags_t   flags;

    bus_in i_bus_in (
        .clk, .reset, .di, .rdy,
        .din
    );

    decoder i_decoder (
        .clk, .reset, .rdy, .state,
        .din,                                       // Opcode at DECODE
        .ctrl
    );

    sequencer #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_sequencer (
        .clk, .reset, .rdy, .din, .ctrl, .flags, .alu_out, .regfile_out,
        .state, .pc, .alu_in, .alu_op
    );

    alu i_alu (
        .clk, .rdy, .alu_in,
        .op(alu_op),
        .alu_out
    );

    reg_flags i_reg_flags (
        .clk, .reset, .rdy, .state, .ctrl, .alu_out,
        .regfile_out, .flags
    );

    bus_out #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_bus_out (
        .clk, .reset, .rdy, .state, .ctrl, .pc, .din, .alu_out, .regfile_out,
        .ab, .do_data, .we
    );

endmodule

/* test/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory (
    input  logic           clk,
    input  logic           rdy,
    input  cpu_pkg::addr_t ab,
    input  cpu_pkg::byte_t do_data,
    input  logic           we,
    output cpu_pkg::byte_t di
);
    import cpu_pkg::*;

    byte_t mem [0:65535];
    addr_t log_addr [0:63];                         // Committed writes in order
    byte_t log_data [0:63];
    int    log_count;

    initial begin
        log_count = 0;
        di        = 8'h00;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'h5c;    // Depends on every address bit
        end
    end

    // One read per rdy-high cycle, data shows up next cycle
    always @(posedge clk) begin
        if (rdy) begin
            di <= mem[ab];
            if (we) begin
                mem[ab] <= do_data;
                if (log_count < 64) begin
                    log_addr[log_count] <= ab;
                    log_data[log_count] <= do_data;
                end
                log_count <= log_count + 1;
            end
        end
    end

endmodule

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam addr_t VECTOR_AT = 16'hfffc;
    localparam addr_t START     = 16'h0200;         // Value stored in the vector
    localparam addr_t END_LOOP  = 16'h02e4;         // Self jump after the last store

    logic  clk;
    logic  reset;
    logic  rdy;
    byte_t di;
    addr_t ab;
    byte_t do_data;
    logic  we;

    int    value_errors;
    int    other_errors;
    addr_t exp_addr [$];
    byte_t exp_data [$];
    addr_t load_ptr;
    int    rd_cycles;                               // rdy-high cycles since reset
    logic  prev_rdy;
    addr_t prev_ab;
    byte_t prev_do;
    logic  prev_we;
    int    seed_val;
    int    waited;

    cpu_core #(.RESET_VECTOR(VECTOR_AT)) i_cpu_core (
        .clk, .reset, .di, .rdy, .ab, .do_data, .we
    );

    tb_memory i_mem (.clk, .rdy, .ab, .do_data, .we, .di);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        seed_val = $urandom(32'h745bdcf3);
        rdy      = 1'b1;
        forever begin
            @(posedge clk);
            rdy <= ($urandom % 4) != 0;             // Stall about one cycle in four
        end
    end

    task automatic check_value(string name, int expected, int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic put(byte_t b);
        i_mem.mem[load_ptr] = b;
        load_ptr++;
    endtask

    task automatic set_load_addr(addr_t a);
        load_ptr = a;
    endtask

    task automatic expect_write(addr_t a, byte_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    function automatic logic [8:0] add_carry(byte_t a, byte_t b, logic c);
        return {1'b0, a} + {1'b0, b} + 9'(c);
    endfunction

    task automatic load_program();
        byte_t prog [$];
        i_mem.mem[VECTOR_AT]     = START[7:0];
        i_mem.mem[VECTOR_AT + 1] = START[15:8];
        prog = '{8'ha9, 8'h5a, 8'h85, 8'h10, 8'ha2, 8'hc3, 8'h8e, 8'h00, 8'h04,
                 8'ha0, 8'h7e, 8'h84, 8'h11,            // Loads and stores
                 8'h09, 8'h81, 8'h85, 8'h12, 8'h29, 8'hf0, 8'h85, 8'h13,
                 8'h49, 8'hff, 8'h85, 8'h14, 8'h18, 8'h69, 8'he0, 8'h85, 8'h15,
                 8'he9, 8'h20, 8'h85, 8'h16,
                 8'ha9, 8'h00, 8'h69, 8'h00, 8'h85, 8'h17,  // Carry out of the SBC
                 8'h38, 8'ha9, 8'h00, 8'h69, 8'h00, 8'h85, 8'h18,
                 8'he8, 8'h86, 8'h19, 8'h88, 8'h84, 8'h1a, 8'h8a, 8'h85, 8'h1b,
                 8'h98, 8'haa, 8'h86, 8'h1c,
                 8'hc9, 8'h7d, 8'hf0, 8'h04, 8'ha9, 8'he1, 8'h85, 8'h20,
                 8'ha9, 8'ha1, 8'h85, 8'h20,
                 8'he0, 8'h10, 8'h90, 8'h04, 8'ha9, 8'ha2, 8'h85, 8'h21,
                 8'h4c, 8'hf0, 8'h02};
        set_load_addr(START);
        foreach (prog[i]) put(prog[i]);
        set_load_addr(16'h02f0);                    // BNE across into page 3
        prog = '{8'ha2, 8'h05, 8'h86, 8'h24, 8'hd0, 8'h16, 8'ha9, 8'he3, 8'h85, 8'h22};
        foreach (prog[i]) put(prog[i]);
        set_load_addr(16'h030c);                    // BMI back across into page 2
        prog = '{8'ha9, 8'ha3, 8'h85, 8'h22, 8'h30, 8'hce,
                 8'ha9, 8'he4, 8'h85, 8'h23, 8'h4c, 8'he4, 8'h02};
        foreach (prog[i]) put(prog[i]);
        set_load_addr(16'h02e0);
        prog = '{8'ha9, 8'ha4, 8'h85, 8'h23, 8'h4c, 8'he4, 8'h02};
        foreach (prog[i]) put(prog[i]);
    endtask

    // 6502 rules applied to the same program
    task automatic build_expected();
        byte_t      a;
        byte_t      x;
        byte_t      y;
        logic       c;
        logic [8:0] r;
        a = 8'h5a;
        expect_write(16'h0010, a);
        x = 8'hc3;
        expect_write(16'h0400, x);
        y = 8'h7e;
        expect_write(16'h0011, y);
        a = a | 8'h81;
        expect_write(16'h0012, a);
        a = a & 8'hf0;
        expect_write(16'h0013, a);
        a = a ^ 8'hff;
        expect_write(16'h0014, a);
        r = add_carry(a, 8'he0, 1'b0);
        {c, a} = r;
        expect_write(16'h0015, a);
        r = add_carry(a, ~8'h20, c);                // SBC is ADC of the complement
        {c, a} = r;
        expect_write(16'h0016, a);
        r = add_carry(8'h00, 8'h00, c);
        expect_write(16'h0017, r[7:0]);
        r = add_carry(8'h00, 8'h00, 1'b1);
        expect_write(16'h0018, r[7:0]);
        x = x + 1;
        expect_write(16'h0019, x);
        y = y - 1;
        expect_write(16'h001a, y);
        a = x;
        expect_write(16'h001b, a);
        a = y;
        x = a;
        expect_write(16'h001c, x);
        if (a != 8'h7d) begin                       // BEQ falls through
            expect_write(16'h0020, 8'he1);
        end
        expect_write(16'h0020, 8'ha1);
        if (x >= 8'h10) begin                       // BCC not taken
            expect_write(16'h0021, 8'ha2);
        end
        expect_write(16'h0024, 8'h05);
        expect_write(16'h0022, 8'ha3);              // 05 is nonzero so BNE taken
        expect_write(16'h0023, 8'ha4);              // A3 is negative so BMI taken
    endtask

    // Outputs of the cycle just ended, seen before the edge updates them
    always @(posedge clk) begin
        if (!reset) begin
            if (!prev_rdy) begin
                assert (ab === prev_ab && do_data === prev_do && we === prev_we) else begin
                    other_errors++;
                    $display("Bus outputs changed during an rdy stall at %t", $time);
                end
            end
            if (rdy) begin
                case (rd_cycles)
                    0: check_value("reset_vector_low", VECTOR_AT, ab);
                    1: check_value("reset_vector_high", VECTOR_AT + 1, ab);
                    2: check_value("first_fetch", START, ab);
                    default: ;
                endcase
                if (rd_cycles < 3) begin
                    check_value("reset_we", 0, we);
                end
                rd_cycles++;
            end
        end
        prev_rdy = rdy;
        prev_ab  = ab;
        prev_do  = do_data;
        prev_we  = we;
    end

    initial begin
        value_errors = 0;
        other_errors = 0;
        rd_cycles    = 0;
        prev_rdy     = 1'b1;
        reset        = 1'b1;
        #1;
        load_program();
        build_expected();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        while (ab != END_LOOP && waited < 5000) begin
            @(posedge clk);
            waited++;
        end
        if (ab != END_LOOP) begin
            other_errors++;
            $display("Program never reached its final loop");
        end
        check_value("write_count", exp_addr.size(), i_mem.log_count);
        foreach (exp_addr[i]) begin
            if (i < i_mem.log_count) begin
                check_value($sformatf("write_%0d_addr", i), exp_addr[i], i_mem.log_addr[i]);
                check_value($sformatf("write_%0d_data", i), exp_data[i], i_mem.log_data[i]);
            end
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* list.f */
logic/cpu_pkg.sv
logic/bus_in.sv
logic/decoder.sv
logic/sequencer.sv
logic/alu.sv
logic/reg_flags.sv
logic/bus_out.sv
logic/cpu_core.sv
test/tb_memory.sv
test/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/bus_in.sv
  - logic/decoder.sv
  - logic/sequencer.sv
  - logic/alu.sv
  - logic/reg_flags.sv
  - logic/bus_out.sv
  - logic/cpu_core.sv
  - target: test
    files:
      - test/tb_memory.sv
      - test/cpu_tb.sv
